// File: source/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word;

    typedef enum logic [6:0] {
        opR    = 7'b0110011,
        opI    = 7'b0010011,
        opS    = 7'b0100011,
        opB    = 7'b1100011,
        opLui  = 7'b0110111,
        opJal  = 7'b1101111,
        opLoad = 7'b0000011,
        opJalr = 7'b1100111
    } opcode;

    typedef enum logic [4:0] {
        stFetch, stDecode,
        stExeR, stExeI,
        stMemAddr, stMemRead, stMemReadWb, stMemWrite,
        stAluWb, stBranch,
        stJal, stJalLink, stJalr, stJalrLink,
        stLui
    } ctrlState;

    typedef enum logic [1:0] {aluAdd, aluSub, aluRType, aluIType} aluOpClass;

    typedef enum logic [2:0] {ctlAdd, ctlSub, ctlAnd, ctlOr, ctlSlt} aluCtl;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKind;

    typedef enum logic [1:0] {srcPc, srcOldPc, srcReg} srcA;

    typedef enum logic [1:0] {srcRegB, srcImm, srcFour} srcB;

    // resAlu bypasses the ALU result register
    typedef enum logic [1:0] {resAluOut, resData, resAlu, resImm} resultKind;

endpackage

// File: source/regFile.sv
module regFile (
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [4:0] ra1,
    input  logic [4:0] ra2,
    input  logic [4:0] wa,
    input  rvPkg::word wd,
    output rvPkg::word rd1,
    output rvPkg::word rd2
);
    import rvPkg::*;

    word regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd; // x0 stays zero
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: source/aluDecoder.sv
module aluDecoder (
    input  rvPkg::aluOpClass aluOp,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,
    output rvPkg::aluCtl     aluCtl
);
    import rvPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd: aluCtl = ctlAdd;
            aluSub: aluCtl = ctlSub;
            default: begin
                case (funct3)
                    3'b000: begin
                        // bit 30 is immediate data for addi
                        if (aluOp == aluRType && funct7b5)
                            aluCtl = ctlSub;
                        else
                            aluCtl = ctlAdd;
                    end
                    3'b010:  aluCtl = ctlSlt;
                    3'b110:  aluCtl = ctlOr;
                    3'b111:  aluCtl = ctlAnd;
                    default: aluCtl = ctlAdd; // unsupported funct3
                endcase
            end
        endcase
    end

endmodule

// File: source/mainController.sv
module mainController (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::opcode     opcode,
    input  logic             memDone,
    output logic             pcUpdate,
    output logic             branch,
    output logic             irWrite,
    output logic             regWrite,
    output logic             memReq,
    output logic             memWrite,
    output logic             adrSrc,
    output rvPkg::aluOpClass aluOp,
    output rvPkg::srcA       srcA,
    output rvPkg::srcB       srcB,
    output rvPkg::immKind    immKind,
    output rvPkg::resultKind resultKind
);
    import rvPkg::*;

    ctrlState state;
    ctrlState nextState;
    rvPkg::immKind memImm;

    assign memImm = (opcode == opS) ? immS : immI; // store vs load offset

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= stFetch;
        else
            state <= nextState;
    end

    always_comb begin
        nextState = state;
        case (state)
            stFetch:    if (memDone) nextState = stDecode;
            stDecode: begin
                case (opcode)
                    opR:     nextState = stExeR;
                    opI:     nextState = stExeI;
                    opS:     nextState = stMemAddr;
                    opLoad:  nextState = stMemAddr;
                    opB:     nextState = stBranch;
                    opJal:   nextState = stJal;
                    opJalr:  nextState = stJalr;
                    opLui:   nextState = stLui;
                    default: nextState = stFetch; // unknown opcode
                endcase
            end
            stExeR:     nextState = stAluWb;
            stExeI:     nextState = stAluWb;
            stMemAddr:  nextState = (opcode == opLoad) ? stMemRead : stMemWrite;
            stMemRead:  if (memDone) nextState = stMemReadWb;
            stMemWrite: if (memDone) nextState = stFetch;
            stJal:      nextState = stJalLink;
            stJalr:     nextState = stJalrLink;
            default:    nextState = stFetch;
        endcase
    end

    always_comb begin
        pcUpdate   = 1'b0;
        branch     = 1'b0;
        irWrite    = 1'b0;
        regWrite   = 1'b0;
        memReq     = 1'b0;
        memWrite   = 1'b0;
        adrSrc     = 1'b0;
        aluOp      = aluAdd;
        srcA       = srcPc;
        srcB       = srcFour;
        immKind    = immI;
        resultKind = resAluOut;
        case (state)
            stFetch: begin
                memReq     = 1'b1;
                irWrite    = memDone;
                pcUpdate   = memDone; // pc + 4
                resultKind = resAlu;
            end
            stDecode: begin
                srcA    = srcOldPc; // branch target into aluOut
                srcB    = srcImm;
                immKind = immB;
            end
            stExeR: begin
                srcA  = srcReg;
                srcB  = srcRegB;
                aluOp = aluRType;
            end
            stExeI: begin
                srcA  = srcReg;
                srcB  = srcImm;
                aluOp = aluIType;
            end
            stMemAddr, stMemRead, stMemWrite: begin
                srcA     = srcReg; // address held in aluOut
                srcB     = srcImm;
                immKind  = memImm;
                adrSrc   = (state != stMemAddr);
                memReq   = (state != stMemAddr);
                memWrite = (state == stMemWrite);
            end
            stMemReadWb: begin
                resultKind = resData;
                regWrite   = 1'b1;
            end
            stAluWb:     regWrite = 1'b1;
            stBranch: begin
                srcA   = srcReg;
                srcB   = srcRegB;
                aluOp  = aluSub;
                branch = 1'b1;
            end
            stJal: begin
                srcA       = srcOldPc;
                srcB       = srcImm;
                immKind    = immJ;
                resultKind = resAlu;
                pcUpdate   = 1'b1;
            end
            stJalr: begin
                srcA       = srcReg;
                srcB       = srcImm;
                resultKind = resAlu;
                pcUpdate   = 1'b1;
            end
            stJalLink, stJalrLink: begin
                srcA       = srcOldPc; // link is old pc + 4
                resultKind = resAlu;
                regWrite   = 1'b1;
            end
            stLui: begin
                immKind    = immU;
                resultKind = resImm;
                regWrite   = 1'b1;
            end
            default: ;
        endcase
    end

    // a request and its direction hold until memory completes
    assert property (@(posedge clk) disable iff (rst)
        memReq && !memDone |=> memReq && $stable(memWrite));
    assert property (@(posedge clk) disable iff (rst) !$isunknown(state));

endmodule

// File: source/controlUnit.sv
module controlUnit (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::opcode     opcode,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,
    input  logic             zero,
    input  logic             neg,
    input  logic             memDone,
    output logic             pcWrite,
    output logic             irWrite,
    output logic             regWrite,
    output logic             memReq,
    output logic             memWrite,
    output logic             adrSrc,
    output rvPkg::aluCtl     aluCtl,
    output rvPkg::srcA       srcA,
    output rvPkg::srcB       srcB,
    output rvPkg::immKind    immKind,
    output rvPkg::resultKind resultKind
);
    import rvPkg::*;

    aluOpClass aluOp;
    logic pcUpdate;
    logic branch;
    logic taken;

    mainController fsm (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .memDone    (memDone),
        .pcUpdate   (pcUpdate),
        .branch     (branch),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .memReq     (memReq),
        .memWrite   (memWrite),
        .adrSrc     (adrSrc),
        .aluOp      (aluOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .immKind    (immKind),
        .resultKind (resultKind)
    );

    aluDecoder aluDec (
        .aluOp    (aluOp),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .aluCtl   (aluCtl)
    );

    always_comb begin
        case (funct3)
            3'b000:  taken = zero;  // beq
            3'b001:  taken = !zero; // bne
            3'b100:  taken = neg;   // blt
            3'b101:  taken = !neg;  // bge
            default: taken = 1'b0;
        endcase
    end

    assign pcWrite = pcUpdate || (branch && taken);

endmodule

// File: source/datapath.sv
module datapath (
    input  logic             clk,
    input  logic             rst,
    input  logic             pcWrite,
    input  logic             irWrite,
    input  logic             regWrite,
    input  logic             adrSrc,
    input  rvPkg::aluCtl     aluCtl,
    input  rvPkg::srcA       srcA,
    input  rvPkg::srcB       srcB,
    input  rvPkg::immKind    immKind,
    input  rvPkg::resultKind resultKind,
    input  rvPkg::word       rdata,
    input  logic             memDone,
    output rvPkg::opcode     opcode,
    output logic [2:0]       funct3,
    output logic             funct7b5,
    output logic             zero,
    output logic             neg,
    output rvPkg::word       addr,
    output rvPkg::word       wdata
);
    import rvPkg::*;

    word pc;
    word oldPc;
    word instr;
    word data;
    word aReg;
    word bReg;
    word aluOut;
    word rd1;
    word rd2;
    word immExt;
    word opA;
    word opB;
    word diff;
    word aluResult;
    word result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= '0;
            instr <= '0;
        end else begin
            if (pcWrite)
                pc <= result;
            if (irWrite)
                instr <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite)
            oldPc <= pc; // pc of the instruction in flight
        if (memDone)
            data <= rdata;
        aReg   <= rd1;
        bReg   <= rd2;
        aluOut <= aluResult;
    end

    assign opcode   = rvPkg::opcode'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    regFile rf (
        .clk (clk),
        .rst (rst),
        .we  (regWrite),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        case (immKind)
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    immExt = {instr[31:12], 12'b0};
            immJ:    immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        case (srcA)
            srcPc:    opA = pc;
            srcOldPc: opA = oldPc;
            default:  opA = aReg;
        endcase
    end

    always_comb begin
        case (srcB)
            srcRegB: opB = bReg;
            srcImm:  opB = immExt;
            default: opB = word'(4);
        endcase
    end

    assign diff = opA - opB;

    always_comb begin
        case (aluCtl)
            ctlSub:  aluResult = diff;
            ctlAnd:  aluResult = opA & opB;
            ctlOr:   aluResult = opA | opB;
            ctlSlt:  aluResult = ($signed(opA) < $signed(opB)) ? word'(1) : '0;
            default: aluResult = opA + opB;
        endcase
    end

    assign zero = (aluResult == '0);
    assign neg  = diff[xlen-1];

    always_comb begin
        case (resultKind)
            resData: result = data;
            resAlu:  result = aluResult;
            resImm:  result = immExt; // lui
            default: result = aluOut;
        endcase
    end

    assign addr  = adrSrc ? aluOut : pc;
    assign wdata = bReg;

endmodule

// File: source/apbMaster.sv
module apbMaster (
    input  logic       clk,
    input  logic       rst,
    input  logic       memReq,
    input  logic       memWrite,
    input  rvPkg::word addr,
    input  rvPkg::word wdata,
    output logic       memDone,
    output rvPkg::word rdata,
    output rvPkg::word paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output rvPkg::word pwdata,
    input  rvPkg::word prdata,
    input  logic       pready
);
    import rvPkg::*;

    typedef enum logic [1:0] {apbIdle, apbSetup, apbAccess} apbPhase;

    apbPhase state;
    apbPhase phase;
    word addrHold;
    word dataHold;
    logic writeHold;

    // setup is the first cycle a request is seen while idle
    assign phase = (state == apbIdle && memReq) ? apbSetup : state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= apbIdle;
        else if (phase == apbSetup)
            state <= apbAccess;
        else if (phase == apbAccess && pready)
            state <= apbIdle;
    end

    always_ff @(posedge clk) begin
        if (phase == apbSetup) begin
            addrHold  <= addr;
            dataHold  <= wdata;
            writeHold <= memWrite;
        end
    end

    assign psel    = (phase != apbIdle);
    assign penable = (phase == apbAccess);
    assign paddr   = (phase == apbSetup) ? addr : addrHold;
    assign pwrite  = (phase == apbSetup) ? memWrite : writeHold;
    assign pwdata  = (phase == apbSetup) ? wdata : dataHold;
    assign memDone = penable && pready; // single cycle pulse
    assign rdata   = prdata;

    // access follows setup with the latched address
    assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> penable && $stable(paddr));
    assert property (@(posedge clk) disable iff (rst) penable && !pready |=> $stable(paddr));

endmodule

// File: source/riscvCore.sv
module riscvCore (
    input  logic       clk,
    input  logic       rst,
    output rvPkg::word paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output rvPkg::word pwdata,
    input  rvPkg::word prdata,
    input  logic       pready
);
    import rvPkg::*;

    rvPkg::opcode opcode;
    logic [2:0] funct3;
    logic funct7b5;
    logic zero;
    logic neg;
    logic pcWrite;
    logic irWrite;
    logic regWrite;
    logic memReq;
    logic memWrite;
    logic memDone;
    logic adrSrc;
    rvPkg::aluCtl aluCtl;
    rvPkg::srcA srcA;
    rvPkg::srcB srcB;
    rvPkg::immKind immKind;
    rvPkg::resultKind resultKind;
    word addr;
    word wdata;
    word rdata;

    controlUnit ctrl (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .zero       (zero),
        .neg        (neg),
        .memDone    (memDone),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .memReq     (memReq),
        .memWrite   (memWrite),
        .adrSrc     (adrSrc),
        .aluCtl     (aluCtl),
        .srcA       (srcA),
        .srcB       (srcB),
        .immKind    (immKind),
        .resultKind (resultKind)
    );

    datapath dp (
        .clk        (clk),
        .rst        (rst),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .adrSrc     (adrSrc),
        .aluCtl     (aluCtl),
        .srcA       (srcA),
        .srcB       (srcB),
        .immKind    (immKind),
        .resultKind (resultKind),
        .rdata      (rdata),
        .memDone    (memDone),
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .zero       (zero),
        .neg        (neg),
        .addr       (addr),
        .wdata      (wdata)
    );

    apbMaster apb (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memWrite (memWrite),
        .addr     (addr),
        .wdata    (wdata),
        .memDone  (memDone),
        .rdata    (rdata),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

endmodule

// File: tb/apbMemory.sv
module apbMemory (
    input  logic       clk,
    input  logic       rst,
    input  rvPkg::word paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  rvPkg::word pwdata,
    output rvPkg::word prdata,
    output logic       pready
);
    import rvPkg::*;

    word mem [256];
    word logAddr [64];
    word logData [64];
    int logCount = 0;
    int protoErrors = 0;
    word lastRead = '1; // address of the last completed read
    logic readyQ = 1'b0;
    word dataQ = '0;
    logic inTransfer = 1'b0;
    int waitLeft = 0;
    word heldAddr;
    logic heldWrite;
    word heldData;

    assign pready = readyQ;
    assign prdata = dataQ;

    initial begin
        word a;
        for (int i = 0; i < 256; i++) begin
            a = word'(i) << 2;
            mem[i] = {a[15:0], ~a[15:0]}; // pattern from the byte address
        end
    end

    task automatic protocolError(input string what);
        $display("APB protocol violation at time %0t: %s", $time, what);
        protoErrors++;
    endtask

    always @(negedge clk) begin
        if (psel && !penable) begin
            // psel rises during reset too, so only a live transfer counts
            if (inTransfer && !rst)
                protocolError("a new setup phase started before the transfer completed");
            inTransfer <= 1'b1;
            heldAddr   <= paddr;
            heldWrite  <= pwrite;
            heldData   <= pwdata;
            waitLeft   <= $urandom % 4; // 0 to 3 wait states
            readyQ     <= 1'b0;
        end else if (psel && penable) begin
            if (!inTransfer)
                protocolError("access phase without a setup phase");
            else if (paddr != heldAddr || pwrite != heldWrite || (pwrite && pwdata != heldData))
                protocolError("address, direction or write data changed during the transfer");
            if (waitLeft > 0) begin
                waitLeft <= waitLeft - 1;
                readyQ   <= 1'b0;
            end else begin
                readyQ     <= 1'b1; // completes on the next rising edge
                inTransfer <= 1'b0;
                if (paddr[31:10] != '0 || paddr[1:0] != 2'b00) begin
                    protocolError("access outside the memory or not word aligned");
                end else if (pwrite) begin
                    mem[paddr[9:2]] <= pwdata;
                    if (logCount < 64) begin
                        logAddr[logCount] <= paddr;
                        logData[logCount] <= pwdata;
                    end
                    logCount <= logCount + 1;
                end else begin
                    dataQ    <= mem[paddr[9:2]];
                    lastRead <= paddr;
                end
            end
        end else begin
            if (penable)
                protocolError("penable high without psel");
            if (inTransfer && !rst)
                protocolError("psel dropped before the transfer completed");
            inTransfer <= 1'b0;
            readyQ     <= 1'b0;
        end
    end

endmodule

// File: tb/riscvCoreTb.sv
module riscvCoreTb;
    import rvPkg::*;

    logic clk;
    logic rst;
    word paddr;
    logic psel;
    logic penable;
    logic pwrite;
    word pwdata;
    word prdata;
    logic pready;

    string rowName [64];
    word rowInstr [64];
    bit rowStores [64];
    word rowAddr [64];
    word rowData [64];
    int rowCount = 0;
    int dataErrors = 0;
    int addrErrors = 0;
    int otherErrors = 0;

    riscvCore dut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    apbMemory slave (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word encodeR(int f3, int f7b5, int rd, int rs1, int rs2);
        return {1'b0, f7b5[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word encodeI(int op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word encodeS(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word encodeB(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word encodeJ(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word encodeU(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic addStep(input string name, input word instr);
        rowName[rowCount]   = name;
        rowInstr[rowCount]  = instr;
        rowStores[rowCount] = 1'b0;
        rowCount++;
    endtask

    task automatic addStore(input string name, input word instr, input word addr, input word data);
        rowName[rowCount]   = name;
        rowInstr[rowCount]  = instr;
        rowStores[rowCount] = 1'b1;
        rowAddr[rowCount]   = addr;
        rowData[rowCount]   = data;
        rowCount++;
    endtask

    task automatic checkWord(input string name, input word expected, input word actual);
        if (actual !== expected) begin
            $display("[ERROR] %s data expected %h actual %h", name, expected, actual);
            dataErrors++;
        end
    endtask

    task automatic checkAddr(input string name, input word expected, input word actual);
        if (actual !== expected) begin
            $display("[ERROR] %s address expected %h actual %h", name, expected, actual);
            addrErrors++;
        end
    endtask

    task automatic buildProgram();
        addStep("addi x1", encodeI(opI, 0, 1, 0, 'h5a));
        addStep("addi x2", encodeI(opI, 0, 2, 0, 'h3c));
        addStore("addi", encodeS(1, 0, 'h200), 32'h200, 32'h0000005a);
        addStep("add", encodeR(0, 0, 3, 1, 2));
        addStore("add", encodeS(3, 0, 'h204), 32'h204, 32'h00000096);
        addStep("sub", encodeR(0, 1, 3, 2, 1));
        addStore("sub", encodeS(3, 0, 'h208), 32'h208, 32'hffffffe2);
        addStep("and", encodeR(7, 0, 3, 1, 2));
        addStore("and", encodeS(3, 0, 'h20c), 32'h20c, 32'h00000018);
        addStep("or", encodeR(6, 0, 3, 1, 2));
        addStore("or", encodeS(3, 0, 'h210), 32'h210, 32'h0000007e);
        addStep("andi", encodeI(opI, 7, 3, 1, 'hf));
        addStore("andi", encodeS(3, 0, 'h214), 32'h214, 32'h0000000a);
        addStep("ori", encodeI(opI, 6, 3, 1, -256));
        addStore("ori", encodeS(3, 0, 'h218), 32'h218, 32'hffffff5a);
        addStep("addi x4", encodeI(opI, 0, 4, 0, -7));
        addStep("slt true", encodeR(2, 0, 3, 4, 1));
        addStore("slt true", encodeS(3, 0, 'h21c), 32'h21c, 32'h00000001);
        addStep("slt false", encodeR(2, 0, 3, 1, 4));
        addStore("slt false", encodeS(3, 0, 'h220), 32'h220, 32'h00000000);
        addStep("slti false", encodeI(opI, 2, 3, 4, -8));
        addStore("slti false", encodeS(3, 0, 'h224), 32'h224, 32'h00000000);
        addStep("slti true", encodeI(opI, 2, 3, 4, -6));
        addStore("slti true", encodeS(3, 0, 'h228), 32'h228, 32'h00000001);
        addStore("sw", encodeS(4, 0, 'h300), 32'h300, 32'hfffffff9);
        addStep("lw", encodeI(opLoad, 2, 5, 0, 'h300));
        addStore("lw", encodeS(5, 0, 'h22c), 32'h22c, 32'hfffffff9);
        addStep("beq taken", encodeB(0, 1, 1, 8));
        addStep("beq skipped", encodeS(0, 0, 'h2f0));
        addStep("beq not taken", encodeB(0, 1, 2, 8));
        addStore("beq not taken", encodeS(1, 0, 'h230), 32'h230, 32'h0000005a);
        addStep("bne taken", encodeB(1, 1, 2, 8));
        addStep("bne skipped", encodeS(0, 0, 'h2f4));
        addStep("bne not taken", encodeB(1, 1, 1, 8));
        addStore("bne not taken", encodeS(2, 0, 'h234), 32'h234, 32'h0000003c);
        addStep("blt taken", encodeB(4, 4, 1, 8));
        addStep("blt skipped", encodeS(0, 0, 'h2f8));
        addStep("blt not taken", encodeB(4, 1, 4, 8));
        addStore("blt not taken", encodeS(4, 0, 'h238), 32'h238, 32'hfffffff9);
        addStep("bge taken", encodeB(5, 1, 4, 8));
        addStep("bge skipped", encodeS(0, 0, 'h2fc));
        addStep("bge not taken", encodeB(5, 4, 1, 8));
        addStore("bge not taken", encodeS(1, 0, 'h23c), 32'h23c, 32'h0000005a);
        addStep("jal", encodeJ(6, 8)); // link 0xb0
        addStep("jal skipped", encodeS(0, 0, 'h2f0));
        addStore("jal", encodeS(6, 0, 'h240), 32'h240, 32'h000000b0);
        addStep("addi x7", encodeI(opI, 0, 7, 0, 'hb8));
        addStep("jalr", encodeI(opJalr, 0, 8, 7, 12)); // target 0xc4, link 0xc0
        addStep("jalr skipped", encodeS(0, 0, 'h2f4));
        addStore("jalr", encodeS(8, 0, 'h244), 32'h244, 32'h000000c0);
        addStep("lui", encodeU(9, 'habcde));
        addStore("lui", encodeS(9, 0, 'h248), 32'h248, 32'habcde000);
        addStep("halt", encodeJ(0, 0)); // jump to itself
    endtask

    initial begin
        int cycles;
        int expected;
        int k;
        bit finished;
        word haltAddr;
        void'($urandom(32'he6ca));
        rst = 1'b1;
        buildProgram();
        expected = 0;
        for (int i = 0; i < rowCount; i++)
            if (rowStores[i])
                expected++;
        haltAddr = word'((rowCount - 1) * 4);
        @(negedge clk);
        for (int i = 0; i < rowCount; i++)
            slave.mem[i] = rowInstr[i];
        repeat (16) @(negedge clk);
        rst <= 1'b0;

        finished = 1'b0;
        cycles = 0;
        while (!finished && cycles < 5000) begin
            @(posedge clk);
            cycles++;
            finished = (slave.logCount >= expected) && (slave.lastRead == haltAddr);
        end

        if (!finished) begin
            $display("Timed out after %0d cycles waiting for the program to reach its end",
                     cycles);
            otherErrors++;
        end else begin
            if (slave.logCount != expected) begin
                $display("Memory received %0d writes but %0d were expected",
                         slave.logCount, expected);
                otherErrors++;
            end
            k = 0;
            for (int i = 0; i < rowCount; i++) begin
                if (rowStores[i]) begin
                    if (k < slave.logCount && k < 64) begin
                        checkAddr(rowName[i], rowAddr[i], slave.logAddr[k]);
                        checkWord(rowName[i], rowData[i], slave.logData[k]);
                    end
                    k++;
                end
            end
        end

        $display("errors: data %0d, address %0d, protocol %0d, other %0d",
                 dataErrors, addrErrors, slave.protoErrors, otherErrors);
        if (dataErrors + addrErrors + slave.protoErrors + otherErrors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sources.f
source/rvPkg.sv
source/regFile.sv
source/aluDecoder.sv
source/mainController.sv
source/controlUnit.sv
source/datapath.sv
source/apbMaster.sv
source/riscvCore.sv
tb/apbMemory.sv
tb/riscvCoreTb.sv
